//--- rtl/wb2axi_pkg.sv
`default_nettype none

// shared widths, vector types and fsm encodings for the wishbone to axi4-lite bridge
package wb2axi_pkg;

   localparam int ADDR_W = 13;            // axi byte address width
   localparam int DATA_W = 32;            // single data lane with one beat per transfer
   localparam int STRB_W = DATA_W / 8;    // one strobe per byte lane
   localparam int OFS_W  = 2;             // byte offset bits below the wishbone word address

   typedef logic [ADDR_W-1:0]       addr_t;        // byte address on the axi side
   typedef logic [ADDR_W-OFS_W-1:0] word_addr_t;   // wishbone drops the byte offset
   typedef logic [DATA_W-1:0]       data_t;
   typedef logic [STRB_W-1:0]       strb_t;        // wishbone sel and axi wstrb alike

   // front end goes from idle to engine busy, then waits for the engine ack to fall
   typedef enum logic [1:0] {IDLE, BUSY, DONE} front_state_t;

   // write engine walks aw, w and b in that order
   typedef enum logic [2:0] {W_IDLE, W_ADDR, W_DATA, W_RESP, W_DONE} wr_state_t;

   // read engine walks ar then r
   typedef enum logic [1:0] {R_IDLE, R_ADDR, R_DATA, R_DONE} rd_state_t;

endpackage

`default_nettype wire

//--- rtl/bridge_req_if.sv
`timescale 1ns/1ps
`default_nettype none

// four-phase request channel from the wishbone front end to one axi engine
// req rises with a stable payload, ack rises when the axi side is finished,
// req falls, then ack falls
interface bridge_req_if
   import wb2axi_pkg::*;
();

   logic  req;     // held until ack is seen
   addr_t addr;    // byte address with the offset bits already zero
   data_t wdata;   // write data that the read engine ignores
   strb_t wstrb;   // byte enables
   logic  ack;     // held until req drops
   data_t rdata;   // read data valid while ack is high

   // front end side
   modport requester (
      output req, addr, wdata, wstrb,
      input  ack, rdata
   );

   // engine side
   modport responder (
      input  req, addr, wdata, wstrb,
      output ack, rdata
   );

endinterface

`default_nettype wire

//--- rtl/wb_front.sv
`timescale 1ns/1ps
`default_nettype none

// wishbone slave front end that picks the engine by we
// and turns its ack into a one-cycle wb ack
module wb_front
   import wb2axi_pkg::*;
(
   input  wire                 i_clk,
   input  wire                 i_rst,
   input  word_addr_t          i_swb_adr,
   input  data_t               i_swb_dat,
   input  strb_t               i_swb_sel,
   input  wire                 i_swb_we,
   input  wire                 i_swb_stb,
   output data_t               o_swb_rdt,
   output logic                o_swb_ack,
   bridge_req_if.requester     wr,
   bridge_req_if.requester     rd
);

   front_state_t state;
   addr_t        addr_q;    // byte address handed to both engines
   data_t        wdata_q;
   strb_t        wstrb_q;
   logic         is_wr;     // which engine owns the current cycle
   logic         wr_req;
   logic         rd_req;
   logic         eng_ack;   // ack of the engine in use

   assign eng_ack = is_wr ? wr.ack : rd.ack;

   // payload goes to both but only one req is ever raised
   assign wr.req   = wr_req;
   assign wr.addr  = addr_q;
   assign wr.wdata = wdata_q;
   assign wr.wstrb = wstrb_q;
   assign rd.req   = rd_req;
   assign rd.addr  = addr_q;
   assign rd.wdata = wdata_q;
   assign rd.wstrb = wstrb_q;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state     <= IDLE;
         is_wr     <= 1'b0;
         wr_req    <= 1'b0;
         rd_req    <= 1'b0;
         o_swb_ack <= 1'b0;
      end else begin
         o_swb_ack <= 1'b0;                 // pulse by default
         case (state)
            IDLE: if (i_swb_stb) begin
               is_wr  <= i_swb_we;
               wr_req <= i_swb_we;
               rd_req <= ~i_swb_we;
               state  <= BUSY;
            end
            BUSY: if (eng_ack) begin           // axi side done
               wr_req    <= 1'b0;
               rd_req    <= 1'b0;
               o_swb_ack <= 1'b1;
               state     <= DONE;
            end
            // stb drops meanwhile, so no stale cycle restarts
            DONE: if (!eng_ack) state <= IDLE;
            default: state <= IDLE;
         endcase
      end
   end

   // capture the wb request when it is accepted
   always_ff @(posedge i_clk) begin
      if (state == IDLE && i_swb_stb) begin
         addr_q  <= {i_swb_adr, {OFS_W{1'b0}}};   // word to byte address
         wdata_q <= i_swb_dat;
         wstrb_q <= i_swb_sel;
      end
      if (state == BUSY && !is_wr && rd.ack) o_swb_rdt <= rd.rdata;   // read data lands with the ack
   end

endmodule

`default_nettype wire

//--- rtl/axi_write_master.sv
`timescale 1ns/1ps
`default_nettype none

// axi4-lite write engine running the address phase, then data, then response
module axi_write_master
   import wb2axi_pkg::*;
(
   input  wire               i_clk,
   input  wire               i_rst,
   bridge_req_if.responder   req,
   // write address channel
   output addr_t             o_awmaddr,
   output logic              o_awmvalid,
   input  wire               i_awmready,
   // write data channel
   output data_t             o_wmdata,
   output strb_t             o_wmstrb,
   output logic              o_wmvalid,
   input  wire               i_wmready,
   // write response channel without a response code
   input  wire               i_bmvalid,
   output logic              o_bmready
);

   wr_state_t state;
   logic      ack_q;

   assign req.ack   = ack_q;
   assign req.rdata = '0;      // writes return nothing

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state      <= W_IDLE;
         o_awmvalid <= 1'b0;
         o_wmvalid  <= 1'b0;
         o_bmready  <= 1'b0;
         ack_q      <= 1'b0;
      end else begin
         case (state)
            W_IDLE: if (req.req) begin
               o_awmvalid <= 1'b1;             // address goes out with its valid
               state      <= W_ADDR;
            end
            W_ADDR: if (i_awmready) begin
               o_awmvalid <= 1'b0;
               o_wmvalid  <= 1'b1;             // data phase only after aw handshake
               state      <= W_DATA;
            end
            W_DATA: if (i_wmready) begin
               o_wmvalid <= 1'b0;
               o_bmready <= 1'b1;
               state     <= W_RESP;
            end
            W_RESP: if (i_bmvalid) begin
               o_bmready <= 1'b0;
               ack_q     <= 1'b1;              // tell the front end
               state     <= W_DONE;
            end
            W_DONE: if (!req.req) begin        // four-phase handshake waits for req low
               ack_q <= 1'b0;
               state <= W_IDLE;
            end
            default: state <= W_IDLE;
         endcase
      end
   end

   // payload latched at start and stable through both phases
   always_ff @(posedge i_clk) begin
      if (state == W_IDLE && req.req) begin
         o_awmaddr <= req.addr;
         o_wmdata  <= req.wdata;
         o_wmstrb  <= req.wstrb;
      end
   end

endmodule

`default_nettype wire

//--- rtl/axi_read_master.sv
`timescale 1ns/1ps
`default_nettype none

// axi4-lite read engine with one address beat and one data beat
module axi_read_master
   import wb2axi_pkg::*;
(
   input  wire               i_clk,
   input  wire               i_rst,
   bridge_req_if.responder   req,
   // read address channel
   output addr_t             o_armaddr,
   output logic              o_armvalid,
   input  wire               i_armready,
   // read data channel has a single beat and no rlast
   input  data_t             i_rmdata,
   input  wire               i_rmvalid,
   output logic              o_rmready
);

   rd_state_t state;
   logic      ack_q;
   data_t     rdata_q;    // held for the front end while ack is high

   assign req.ack   = ack_q;
   assign req.rdata = rdata_q;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state      <= R_IDLE;
         o_armvalid <= 1'b0;
         o_rmready  <= 1'b0;
         ack_q      <= 1'b0;
      end else begin
         case (state)
            R_IDLE: if (req.req) begin
               o_armvalid <= 1'b1;
               state      <= R_ADDR;
            end
            R_ADDR: if (i_armready) begin
               o_armvalid <= 1'b0;
               o_rmready  <= 1'b1;             // ready only once the address is taken
               state      <= R_DATA;
            end
            R_DATA: if (i_rmvalid) begin
               o_rmready <= 1'b0;
               ack_q     <= 1'b1;
               state     <= R_DONE;
            end
            R_DONE: if (!req.req) begin
               ack_q <= 1'b0;
               state <= R_IDLE;
            end
            default: state <= R_IDLE;
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (state == R_IDLE && req.req) o_armaddr <= req.addr;
      if (state == R_DATA && i_rmvalid) rdata_q <= i_rmdata;   // r handshake
   end

endmodule

`default_nettype wire

//--- rtl/wb2axi_bridge.sv
`timescale 1ns/1ps
`default_nettype none

// wishbone slave to axi4-lite master bridge with one transfer in flight at a time
module wb2axi_bridge
   import wb2axi_pkg::*;
(
   input  wire         i_clk,
   input  wire         i_rst,
   // wishbone slave port
   input  word_addr_t  i_swb_adr,
   input  data_t       i_swb_dat,
   input  strb_t       i_swb_sel,
   input  wire         i_swb_we,
   input  wire         i_swb_stb,
   output data_t       o_swb_rdt,
   output logic        o_swb_ack,
   // axi write address
   output addr_t       o_awmaddr,
   output logic        o_awmvalid,
   input  wire         i_awmready,
   // axi write data
   output data_t       o_wmdata,
   output strb_t       o_wmstrb,
   output logic        o_wmvalid,
   input  wire         i_wmready,
   // axi write response
   input  wire         i_bmvalid,
   output logic        o_bmready,
   // axi read address
   output addr_t       o_armaddr,
   output logic        o_armvalid,
   input  wire         i_armready,
   // axi read data
   input  data_t       i_rmdata,
   input  wire         i_rmvalid,
   output logic        o_rmready
);

   bridge_req_if wr_req ();   // front end to write engine
   bridge_req_if rd_req ();   // front end to read engine

   wb_front u_front (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_swb_adr  (i_swb_adr),
      .i_swb_dat  (i_swb_dat),
      .i_swb_sel  (i_swb_sel),
      .i_swb_we   (i_swb_we),
      .i_swb_stb  (i_swb_stb),
      .o_swb_rdt  (o_swb_rdt),
      .o_swb_ack  (o_swb_ack),
      .wr         (wr_req),
      .rd         (rd_req)
   );

   axi_write_master u_wr (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .req        (wr_req),
      .o_awmaddr  (o_awmaddr),
      .o_awmvalid (o_awmvalid),
      .i_awmready (i_awmready),
      .o_wmdata   (o_wmdata),
      .o_wmstrb   (o_wmstrb),
      .o_wmvalid  (o_wmvalid),
      .i_wmready  (i_wmready),
      .i_bmvalid  (i_bmvalid),
      .o_bmready  (o_bmready)
   );

   axi_read_master u_rd (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .req        (rd_req),
      .o_armaddr  (o_armaddr),
      .o_armvalid (o_armvalid),
      .i_armready (i_armready),
      .i_rmdata   (i_rmdata),
      .i_rmvalid  (i_rmvalid),
      .o_rmready  (o_rmready)
   );

endmodule

`default_nettype wire

//--- bench/axi_slave_model.sv
`timescale 1ns/1ps
`default_nettype none

// axi4-lite slave with a word memory and random 0..3 cycle handshake delays
// only one transfer is ever in flight, so one delay counter serves all channels
module axi_slave_model
   import wb2axi_pkg::*;
#(
   parameter int unsigned SEED = 1
) (
   input  wire   i_clk,
   input  wire   i_rst,
   input  addr_t i_awaddr,
   input  wire   i_awvalid,
   output logic  o_awready,
   input  data_t i_wdata,
   input  strb_t i_wstrb,
   input  wire   i_wvalid,
   output logic  o_wready,
   output logic  o_bvalid,
   input  wire   i_bready,
   input  addr_t i_araddr,
   input  wire   i_arvalid,
   output logic  o_arready,
   output data_t o_rdata,
   output logic  o_rvalid,
   input  wire   i_rready
);

   data_t       mem [2**(ADDR_W-OFS_W)];
   int unsigned lcg = SEED;
   logic [1:0]  dly;        // cycles left before the next ready or valid
   word_addr_t  waddr;      // word index of the pending write
   word_addr_t  raddr;
   logic        b_pend;     // write data taken, response not yet raised
   logic        r_pend;     // read address taken, data not yet raised
   logic        b_take;     // bvalid met bready at the last rising edge
   logic        r_take;

   function automatic logic [1:0] next_delay();
      lcg = lcg * 32'd1664525 + 32'd1013904223;
      return lcg[29:28];    // upper bits since the low ones cycle too fast
   endfunction

   initial begin
      o_awready <= 1'b0;
      o_wready  <= 1'b0;
      o_bvalid  <= 1'b0;
      o_arready <= 1'b0;
      o_rvalid  <= 1'b0;
      o_rdata   <= '0;
      // fill mixes every address bit
      for (int i = 0; i < 2**(ADDR_W-OFS_W); i++) begin
         mem[i] = data_t'(i) * 32'h9E37_79B9 + 32'h0F1E_2D3C;
      end
   end

   always @(posedge i_clk) begin
      b_take <= !i_rst && o_bvalid && i_bready;
      r_take <= !i_rst && o_rvalid && i_rready;
   end

   // outputs change on the falling edge only
   always @(negedge i_clk) begin
      if (i_rst) begin
         o_awready <= 1'b0;
         o_wready  <= 1'b0;
         o_bvalid  <= 1'b0;
         o_arready <= 1'b0;
         o_rvalid  <= 1'b0;
         b_pend    <= 1'b0;
         r_pend    <= 1'b0;
         dly       <= next_delay();
      end else begin
         o_awready <= 1'b0;               // readies are one-cycle pulses
         o_wready  <= 1'b0;
         o_arready <= 1'b0;
         if (b_take) o_bvalid <= 1'b0;
         if (r_take) o_rvalid <= 1'b0;
         // valid cannot drop without ready, so a raised ready always completes
         if (i_awvalid && !o_awready) begin
            if (dly == 2'd0) begin
               o_awready <= 1'b1;
               waddr     <= i_awaddr[ADDR_W-1:OFS_W];
               dly       <= next_delay();
            end else begin
               dly <= dly - 2'd1;
            end
         end
         if (i_wvalid && !o_wready) begin
            if (dly == 2'd0) begin
               o_wready <= 1'b1;
               for (int b = 0; b < STRB_W; b++) begin
                  if (i_wstrb[b]) mem[waddr][8*b +: 8] = i_wdata[8*b +: 8];
               end
               b_pend <= 1'b1;
               dly    <= next_delay();
            end else begin
               dly <= dly - 2'd1;
            end
         end
         if (b_pend && !o_bvalid) begin
            if (dly == 2'd0) begin
               o_bvalid <= 1'b1;          // held until bready is seen
               b_pend   <= 1'b0;
               dly      <= next_delay();
            end else begin
               dly <= dly - 2'd1;
            end
         end
         if (i_arvalid && !o_arready) begin
            if (dly == 2'd0) begin
               o_arready <= 1'b1;
               raddr     <= i_araddr[ADDR_W-1:OFS_W];
               r_pend    <= 1'b1;
               dly       <= next_delay();
            end else begin
               dly <= dly - 2'd1;
            end
         end
         if (r_pend && !o_rvalid) begin
            if (dly == 2'd0) begin
               o_rvalid <= 1'b1;
               o_rdata  <= mem[raddr];
               r_pend   <= 1'b0;
               dly      <= next_delay();
            end else begin
               dly <= dly - 2'd1;
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- bench/wb2axi_assertions.sv
`timescale 1ns/1ps
`default_nettype none

// axi and wishbone protocol checks bound into the bridge top level
module wb2axi_assertions
   import wb2axi_pkg::*;
(
   input wire   i_clk,
   input wire   i_rst,
   input wire   i_stb,
   input wire   i_ack,
   input wire   i_awvalid,
   input wire   i_awready,
   input addr_t i_awaddr,
   input wire   i_wvalid,
   input wire   i_wready,
   input data_t i_wdata,
   input strb_t i_wstrb,
   input wire   i_arvalid,
   input wire   i_arready,
   input addr_t i_araddr
);

   int unsigned fail_cnt = 0;   // number of assertion failures

   // each valid holds with its payload until ready
   aw_hold: assert property (@(posedge i_clk) disable iff (i_rst)
      i_awvalid && !i_awready |=> i_awvalid && $stable(i_awaddr))
      else begin
         $error("awvalid dropped or awaddr changed before awready");
         fail_cnt++;
      end

   w_hold: assert property (@(posedge i_clk) disable iff (i_rst)
      i_wvalid && !i_wready |=> i_wvalid && $stable(i_wdata) && $stable(i_wstrb))
      else begin
         $error("wvalid dropped or write payload changed before wready");
         fail_cnt++;
      end

   ar_hold: assert property (@(posedge i_clk) disable iff (i_rst)
      i_arvalid && !i_arready |=> i_arvalid && $stable(i_araddr))
      else begin
         $error("arvalid dropped or araddr changed before arready");
         fail_cnt++;
      end

   ack_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
      i_ack |=> !i_ack)
      else begin
         $error("wishbone ack longer than one cycle");
         fail_cnt++;
      end

   ack_in_cycle: assert property (@(posedge i_clk) disable iff (i_rst)
      i_ack |-> i_stb)
      else begin
         $error("wishbone ack without stb");
         fail_cnt++;
      end

   // reads and writes never overlap
   one_dir: assert property (@(posedge i_clk) disable iff (i_rst)
      !((i_awvalid || i_wvalid) && i_arvalid))
      else begin
         $error("read and write valid active together");
         fail_cnt++;
      end

endmodule

bind wb2axi_bridge wb2axi_assertions u_checks (
   .i_clk     (i_clk),
   .i_rst     (i_rst),
   .i_stb     (i_swb_stb),
   .i_ack     (o_swb_ack),
   .i_awvalid (o_awmvalid),
   .i_awready (i_awmready),
   .i_awaddr  (o_awmaddr),
   .i_wvalid  (o_wmvalid),
   .i_wready  (i_wmready),
   .i_wdata   (o_wmdata),
   .i_wstrb   (o_wmstrb),
   .i_arvalid (o_armvalid),
   .i_arready (i_armready),
   .i_araddr  (o_armaddr)
);

`default_nettype wire

//--- bench/tb_wb2axi_bridge.sv
`timescale 1ns/1ps
`default_nettype none

// random wishbone traffic through the bridge into the axi slave model
module tb_wb2axi_bridge
   import wb2axi_pkg::*;
();

   localparam int unsigned SEED    = 88;
   localparam int          N_TRANS = 300;
   localparam int          CLK_NS  = 8;
   localparam int          WORDS   = 2**(ADDR_W-OFS_W);

   logic       i_clk, i_rst;
   word_addr_t i_swb_adr;
   data_t      i_swb_dat, o_swb_rdt;
   strb_t      i_swb_sel;
   logic       i_swb_we, i_swb_stb, o_swb_ack;
   addr_t      o_awmaddr, o_armaddr;
   data_t      o_wmdata, i_rmdata;
   strb_t      o_wmstrb;
   logic       o_awmvalid, i_awmready, o_wmvalid, i_wmready, i_bmvalid, o_bmready;
   logic       o_armvalid, i_armready, i_rmvalid, o_rmready;

   data_t       ref_mem [WORDS];   // expected contents of the slave memory
   int unsigned lcg = SEED;
   int          err_data, err_addr, err_strb, err_misc;
   int          ack_cnt;

   wb2axi_bridge u_dut (.*);

   axi_slave_model #(.SEED(SEED)) u_slave (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_awaddr  (o_awmaddr),
      .i_awvalid (o_awmvalid),
      .o_awready (i_awmready),
      .i_wdata   (o_wmdata),
      .i_wstrb   (o_wmstrb),
      .i_wvalid  (o_wmvalid),
      .o_wready  (i_wmready),
      .o_bvalid  (i_bmvalid),
      .i_bready  (o_bmready),
      .i_araddr  (o_armaddr),
      .i_arvalid (o_armvalid),
      .o_arready (i_armready),
      .o_rdata   (i_rmdata),
      .o_rvalid  (i_rmvalid),
      .i_rready  (o_rmready)
   );

   function automatic int unsigned next_random();
      lcg = lcg * 32'd1103515245 + 32'd12345;
      return {lcg[15:0], lcg[31:16]};   // swap halves because the low bits are weak
   endfunction

   // byte lanes with sel set take the new data
   function automatic data_t merge_bytes(data_t old_w, data_t new_w, strb_t sel);
      data_t res;
      res = old_w;
      for (int b = 0; b < STRB_W; b++) begin
         if (sel[b]) res[8*b +: 8] = new_w[8*b +: 8];
      end
      return res;
   endfunction

   task automatic check_data(string name, data_t got, data_t exp);
      if (got !== exp) begin
         err_data++;
         $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_addr(string name, addr_t got, addr_t exp);
      if (got !== exp) begin
         err_addr++;
         $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_strb(string name, strb_t got, strb_t exp);
      if (got !== exp) begin
         err_strb++;
         $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   initial begin
      i_clk = 1'b0;
      forever #(CLK_NS/2) i_clk = ~i_clk;
   end

   // wishbone inputs are held through the cycle, so they give the expected values
   always @(posedge i_clk) begin
      if (!i_rst) begin
         if (o_awmvalid && i_awmready) check_addr("o_awmaddr", o_awmaddr, {i_swb_adr, 2'b00});
         if (o_armvalid && i_armready) check_addr("o_armaddr", o_armaddr, {i_swb_adr, 2'b00});
         if (o_wmvalid && i_wmready) begin
            check_data("o_wmdata", o_wmdata, i_swb_dat);
            check_strb("o_wmstrb", o_wmstrb, i_swb_sel);
         end
         if (o_swb_ack) begin
            ack_cnt++;
            if (i_swb_we) begin
               ref_mem[i_swb_adr] = merge_bytes(ref_mem[i_swb_adr], i_swb_dat, i_swb_sel);
            end else begin
               check_data("o_swb_rdt", o_swb_rdt, ref_mem[i_swb_adr]);
            end
         end
      end
   end

   initial begin
      int unsigned r;
      int          asrt;
      i_rst     = 1'b1;
      i_swb_stb = 1'b0;
      i_swb_we  = 1'b0;
      i_swb_adr = '0;
      i_swb_dat = '0;
      i_swb_sel = '0;
      for (int i = 0; i < WORDS; i++) begin
         ref_mem[i] = data_t'(i) * 32'h9E37_79B9 + 32'h0F1E_2D3C;   // slave's power-up fill
      end
      repeat (16) @(negedge i_clk);
      i_rst = 1'b0;
      repeat (4) begin                   // quiet bus before the first stb
         @(negedge i_clk);
         if (o_swb_ack || o_awmvalid || o_wmvalid || o_bmready || o_armvalid || o_rmready) begin
            err_misc++;
            $display("ack, valid or ready output active after reset with no request");
         end
      end
      for (int n = 0; n < N_TRANS; n++) begin
         r         = next_random();
         i_swb_we  = r[0];
         i_swb_adr = r[20] ? r[18:8] : {6'b0, r[12:8]};   // mostly a small window, so reads hit writes
         i_swb_sel = i_swb_we ? r[4:1] : 4'hF;
         i_swb_dat = next_random();
         i_swb_stb = 1'b1;
         do @(negedge i_clk); while (!o_swb_ack);
         @(negedge i_clk);                // stb drops the cycle after the ack
         i_swb_stb = 1'b0;
         repeat (1 + r[23:22]) @(negedge i_clk);
      end
      repeat (4) @(negedge i_clk);
      if (ack_cnt != N_TRANS) begin
         err_misc++;
         $display("%0d acknowledges seen for %0d wishbone cycles", ack_cnt, N_TRANS);
      end
      asrt = int'(u_dut.u_checks.fail_cnt);
      $display("errors: data %0d, addr %0d, strb %0d, other %0d, assertion %0d",
               err_data, err_addr, err_strb, err_misc, asrt);
      if (err_data + err_addr + err_strb + err_misc + asrt == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

   // 20 cycles per transaction is well above the average random back-pressure
   initial begin
      #((N_TRANS * 20 + 16) * CLK_NS);
      $display("timeout, %0d of %0d wishbone cycles acknowledged", ack_cnt, N_TRANS);
      $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- src.f
rtl/wb2axi_pkg.sv
rtl/bridge_req_if.sv
rtl/wb_front.sv
rtl/axi_write_master.sv
rtl/axi_read_master.sv
rtl/wb2axi_bridge.sv
bench/axi_slave_model.sv
bench/wb2axi_assertions.sv
bench/tb_wb2axi_bridge.sv

//--- run.sh
#!/bin/sh
# build the bench with verilator, run it, then decide from the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -f src.f \
   --top-module tb_wb2axi_bridge -o sim_wb2axi > build.log 2>&1 \
   || { cat build.log; echo "verilator build failed"; exit 1; }
./obj_dir/sim_wb2axi +verilator+error+limit+1000 > sim.log 2>&1 \
   || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1
grep -q "TESTBENCH PASSED" sim.log || exit 1
exit 0
